// ==== compile.f ====
hdl/operand_pkg.sv
hdl/inst_field_decoder.sv
hdl/forward_match.sv
hdl/register_file.sv
hdl/operand_select.sv
hdl/operand_stage.sv
sim/operand_stage_assertions.sv
sim/operand_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the operand stage testbench

VERILATOR ?= verilator
TOP       ?= operand_stage_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/operand_stage_tb.sv ====
`timescale 1ns/1ps

module operand_stage_tb import operand_pkg::*; ();

    localparam int PERIOD       = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 3000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 20) * PERIOD;

    logic      clk;
    logic      rst;
    logic      valid;
    addr_t     pc;
    inst_t     inst;
    ctrl_t     ctrl;
    fw_ctrl_t  fw [NUM_FW_SRC];
    logic      wb_en;
    reg_addr_t wb_addr;
    xlen_t     wb_data;
    xlen_t     op1_data;
    xlen_t     op2_data;
    xlen_t     rs2_data;
    logic      is_datahazard;

    integer seed;
    xlen_t  mirror [NUM_REGS]; // Expected architectural state

    operand_stage u_dut (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .pc            (pc),
        .inst          (inst),
        .ctrl          (ctrl),
        .fw            (fw),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .op1_data      (op1_data),
        .op2_data      (op2_data),
        .rs2_data      (rs2_data),
        .is_datahazard (is_datahazard)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $fatal(1);
    end

    // Mostly x0 to x3, so sources collide with each other and with x0
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] != 3'd0) begin
            return {3'b000, r[4:3]};
        end
        return r[9:5];
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [2:0]  sel2;
        r = $random(seed);
        inst = r;
        inst[19:15] = pick_reg();
        inst[24:20] = pick_reg();
        r = $random(seed);
        pc = r;
        r = $random(seed);
        valid = r[0] | r[1];
        sel2 = (r[5:3] > 3'd5) ? 3'd0 : r[5:3];
        ctrl.op1_sel = op1_sel_t'(r[7:6]);
        ctrl.op2_sel = op2_sel_t'(sel2);
        for (int i = 0; i < NUM_FW_SRC; i++) begin
            r = $random(seed);
            fw[i].valid   = r[0];
            fw[i].fwdable = r[1] | r[2]; // Mostly ready, sometimes still in flight
            fw[i].addr    = pick_reg();
            r = $random(seed);
            fw[i].wdata   = r;
        end
        r = $random(seed);
        wb_en   = r[0];
        wb_addr = pick_reg();
        r = $random(seed);
        wb_data = r;
    endtask

    // Lowest index that names the register wins, x0 is never bypassed
    task automatic resolve(input reg_addr_t a, output xlen_t val, output logic stall);
        logic found;
        val   = mirror[a];
        stall = 1'b0;
        found = 1'b0;
        for (int i = 0; i < NUM_FW_SRC; i++) begin
            if (!found && a != 5'd0 && fw[i].valid && fw[i].addr == a) begin
                val   = fw[i].wdata;
                stall = !fw[i].fwdable;
                found = 1'b1;
            end
        end
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs(input int cyc);
        xlen_t v1;
        xlen_t v2;
        logic  s1;
        logic  s2;
        xlen_t exp_op1;
        xlen_t exp_op2;
        resolve(inst[19:15], v1, s1);
        resolve(inst[24:20], v2, s2);
        case (ctrl.op1_sel)
            OP1_RS1: exp_op1 = v1;
            OP1_PC:  exp_op1 = pc;
            OP1_IMZ: exp_op1 = {27'd0, inst[19:15]};
            default: exp_op1 = '0;
        endcase
        case (ctrl.op2_sel)
            OP2_RS2W: exp_op2 = v2;
            OP2_IMI:  exp_op2 = {{20{inst[31]}}, inst[31:20]};
            OP2_IMS:  exp_op2 = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OP2_IMJ:  exp_op2 = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OP2_IMU:  exp_op2 = {inst[31:12], 12'h000};
            default:  exp_op2 = '0;
        endcase
        check_xlen($sformatf("op1 cycle %0d", cyc), exp_op1, op1_data);
        check_xlen($sformatf("op2 cycle %0d", cyc), exp_op2, op2_data);
        check_xlen($sformatf("rs2_data cycle %0d", cyc), v2, rs2_data);
        check_flag($sformatf("hazard cycle %0d", cyc), valid && (s1 || s2), is_datahazard);
    endtask

    initial begin
        seed       = 16751;
        rst        = 1'b1;
        valid      = 1'b0;
        pc         = '0;
        inst       = '0;
        ctrl       = '0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        for (int i = 0; i < NUM_FW_SRC; i++) begin
            fw[i] = '0;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            mirror[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_random();
            #(PERIOD / 2 - 1); // Sample just before the rising edge
            check_outputs(cyc);
            @(posedge clk);
            if (wb_en && wb_addr != 5'd0) begin
                mirror[wb_addr] = wb_data;
            end
            @(negedge clk);
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== sim/operand_stage_assertions.sv ====
`timescale 1ns/1ps

module operand_stage_assertions import operand_pkg::*; (
    input logic  clk,
    input logic  valid,
    input addr_t pc,
    input ctrl_t ctrl,
    input xlen_t op1_data,
    input xlen_t op2_data,
    input xlen_t rs2_data,
    input logic  is_datahazard
);

    // A stall request is meaningless without an instruction in the stage
    a_hazard_needs_valid: assert property (@(posedge clk) is_datahazard |-> valid)
        else $error("Hazard flag is high while valid is low");

    a_op1_is_pc: assert property (@(posedge clk) ctrl.op1_sel == OP1_PC |-> op1_data == pc)
        else $error("op1 does not carry pc although op1_sel selects it");

    // Register-register ops and stores see the same resolved rs2
    a_op2_is_rs2: assert property (
        @(posedge clk) ctrl.op2_sel == OP2_RS2W |-> op2_data == rs2_data)
        else $error("op2 differs from rs2_data although op2_sel selects rs2");

endmodule

bind operand_stage operand_stage_assertions u_assertions (
    .clk           (clk),
    .valid         (valid),
    .pc            (pc),
    .ctrl          (ctrl),
    .op1_data      (op1_data),
    .op2_data      (op2_data),
    .rs2_data      (rs2_data),
    .is_datahazard (is_datahazard)
);

// ==== hdl/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage import operand_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  addr_t     pc,
    input  inst_t     inst,
    input  ctrl_t     ctrl,
    input  fw_ctrl_t  fw [NUM_FW_SRC],
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  xlen_t     wb_data,
    output xlen_t     op1_data,
    output xlen_t     op2_data,
    output xlen_t     rs2_data,
    output logic      is_datahazard
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    imm_set_t  imms;
    fw_hit_t   hits [NUM_FW_SRC];
    xlen_t     rs1_reg;
    xlen_t     rs2_reg;

    inst_field_decoder u_decoder (
        .inst     (inst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .imms     (imms)
    );

    // One comparator per pending-write source
    for (genvar g = 0; g < NUM_FW_SRC; g++) begin : g_fw_match
        forward_match u_match (
            .fw       (fw[g]),
            .rs1_addr (rs1_addr),
            .rs2_addr (rs2_addr),
            .hit      (hits[g])
        );
    end

    register_file u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_reg  (rs1_reg),
        .rs2_reg  (rs2_reg)
    );

    operand_select u_select (
        .valid         (valid),
        .ctrl          (ctrl),
        .pc            (pc),
        .imms          (imms),
        .fw            (fw),
        .hits          (hits),
        .rs1_reg       (rs1_reg),
        .rs2_reg       (rs2_reg),
        .op1_data      (op1_data),
        .op2_data      (op2_data),
        .rs2_data      (rs2_data),
        .is_datahazard (is_datahazard)
    );

endmodule

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ps

module operand_select import operand_pkg::*; (
    input  logic     valid,
    input  ctrl_t    ctrl,
    input  addr_t    pc,
    input  imm_set_t imms,
    input  fw_ctrl_t fw [NUM_FW_SRC],
    input  fw_hit_t  hits [NUM_FW_SRC],
    input  xlen_t    rs1_reg,
    input  xlen_t    rs2_reg,
    output xlen_t    op1_data,
    output xlen_t    op2_data,
    output xlen_t    rs2_data,
    output logic     is_datahazard
);

    xlen_t rs1_val;
    xlen_t rs2_val;
    logic  rs1_stall;
    logic  rs2_stall;

    // Walk from the oldest source to the youngest so the lowest index is applied last
    always_comb begin
        rs1_val   = rs1_reg;
        rs2_val   = rs2_reg;
        rs1_stall = 1'b0;
        rs2_stall = 1'b0;
        for (int i = NUM_FW_SRC - 1; i >= 0; i--) begin
            if (hits[i].hit_rs1) begin
                rs1_val   = fw[i].wdata;
                rs1_stall = !fw[i].fwdable;
            end
            if (hits[i].hit_rs2) begin
                rs2_val   = fw[i].wdata;
                rs2_stall = !fw[i].fwdable;
            end
        end
    end

    // Only the winning source decides, an older ready value does not help
    assign is_datahazard = valid && (rs1_stall || rs2_stall);

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1_data = rs1_val;
            OP1_PC:  op1_data = pc;
            OP1_IMZ: op1_data = imms.imm_z;
            default: op1_data = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2W: op2_data = rs2_val;
            OP2_IMI:  op2_data = imms.imm_i;
            OP2_IMS:  op2_data = imms.imm_s;
            OP2_IMJ:  op2_data = imms.imm_j;
            OP2_IMU:  op2_data = imms.imm_u;
            default:  op2_data = '0;
        endcase
    end

    assign rs2_data = rs2_val; // Stores need rs2 even when op2 carries the offset

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file import operand_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  xlen_t     wb_data,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_reg,
    output xlen_t     rs2_reg
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // x0 stays at its reset value
        end
    end

    // The same-cycle write is covered by the writeback forwarding entry
    assign rs1_reg = regs[rs1_addr];
    assign rs2_reg = regs[rs2_addr];

endmodule

// ==== hdl/forward_match.sv ====
`timescale 1ns/1ps

module forward_match import operand_pkg::*; (
    input  fw_ctrl_t  fw,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output fw_hit_t   hit
);

    logic rs1_is_zero;
    logic rs2_is_zero;

    // x0 is hardwired, so a pending write to it must never be bypassed
    assign rs1_is_zero = (rs1_addr == '0);
    assign rs2_is_zero = (rs2_addr == '0);

    assign hit.hit_rs1 = fw.valid && (fw.addr == rs1_addr) && !rs1_is_zero;
    assign hit.hit_rs2 = fw.valid && (fw.addr == rs2_addr) && !rs2_is_zero;

endmodule

// ==== hdl/inst_field_decoder.sv ====
`timescale 1ns/1ps

module inst_field_decoder import operand_pkg::*; (
    input  inst_t     inst,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output imm_set_t  imms
);

    logic        sign;
    logic [11:0] i_field;
    logic [11:0] s_field;
    logic [20:0] j_field;
    logic [19:0] u_field;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // Bit 31 is the sign for every signed RV32I immediate
    assign sign = inst[31];

    assign i_field = inst[31:20];

    // Store splits the offset around the rs2 field
    assign s_field = {inst[31:25], inst[11:7]};

    // Jump offset is scrambled in the encoding and always even
    assign j_field = {
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign u_field = inst[31:12];

    always_comb begin
        imms.imm_i = {{(XLEN-12){sign}}, i_field};
        imms.imm_s = {{(XLEN-12){sign}}, s_field};
        imms.imm_j = {{(XLEN-21){sign}}, j_field};
        imms.imm_u = {u_field, 12'b0};
        imms.imm_z = {{(XLEN-REG_ADDR_W){1'b0}}, inst[19:15]}; // CSR uimm sits in the rs1 slot
    end

endmodule

// ==== hdl/operand_pkg.sv ====
package operand_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Index 0 is execute, then memory, CSR and writeback; lower index wins
    localparam int NUM_FW_SRC = 4;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // OP1_X and OP2_X both produce a zero operand
    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_IMZ,
        OP1_X
    } op1_sel_t;

    typedef enum logic [2:0] {
        OP2_RS2W,
        OP2_IMI,
        OP2_IMS,
        OP2_IMJ,
        OP2_IMU,
        OP2_X
    } op2_sel_t;

    typedef struct packed {
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
    } ctrl_t;

    // One write that a later stage still owes the register file
    typedef struct packed {
        logic      valid;
        logic      fwdable; // Data is already known and can be bypassed
        reg_addr_t addr;
        xlen_t     wdata;
    } fw_ctrl_t;

    typedef struct packed {
        logic hit_rs1;
        logic hit_rs2;
    } fw_hit_t;

    typedef struct packed {
        xlen_t imm_i;
        xlen_t imm_s;
        xlen_t imm_j;
        xlen_t imm_u;
        xlen_t imm_z;
    } imm_set_t;

endpackage
